/* Bender.yml */
package:
  name: elevator_report

export_include_dirs:
  - common

sources:
  - files:
      - common/elev_report_pkg.sv
      - hw/report_control.sv
      - hw/content_reader.sv
      - hw/queue_reader.sv
      - hw/serial_tx/serial_tx.sv
      - hw/elevator_report.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/elevator_report_chk.sv
      - test/elevator_report_tb.sv

/* common/elev_report_defs.svh */
`ifndef ELEV_REPORT_DEFS_SVH
`define ELEV_REPORT_DEFS_SVH

// **************************************************
// report sizes
// **************************************************

// floor, flags, load and checksum
`define CONTENT_WORDS 4

// entries in the request queue, walked by a 3 bit pointer
`define QUEUE_DEPTH 8

// **************************************************
// serial timing
// **************************************************

// clock cycles spent on every bit of the 8N1 frame
`define CLKS_PER_BIT 8

`endif

/* common/elev_report_pkg.sv */
package elev_report_pkg;

    // **************************************************
    // car status
    // **************************************************

    typedef enum logic [1:0] {
        dir_idle = 2'd0,
        dir_up   = 2'd1,
        dir_down = 2'd2
    } direction_t;

    typedef struct packed {
        logic [3:0] floor;
        direction_t direction;
        logic       door_open;
        logic [7:0] load;
    } car_status_t;

    // **************************************************
    // request queue
    // **************************************************

    // hall call, the car has to pick someone up at this floor
    typedef struct packed {
        logic       tag;
        logic [3:0] floor;
        logic       call_up;
        logic [1:0] spare;
    } origin_entry_t;

    // car call, tied to the passenger slot that pressed it
    typedef struct packed {
        logic       tag;
        logic [3:0] floor;
        logic [2:0] slot;
    } destination_entry_t;

    // the top bit tells the two views apart, 1 for an origin call
    typedef union packed {
        origin_entry_t      origin;
        destination_entry_t destination;
    } queue_entry_u;

    typedef struct packed {
        logic         strobe;
        logic [2:0]   index;
        queue_entry_u entry;
    } queue_write_t;

endpackage

/* hw/content_reader.sv */
`timescale 1ns/1ns
`include "elev_report_defs.svh"

module content_reader (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         clear,
    input  logic                         count_content,
    input  elev_report_pkg::car_status_t car_status,
    output logic [7:0]                   content_byte,
    output logic                         content_last
);

    import elev_report_pkg::*;

    localparam int ptr_w = $clog2(`CONTENT_WORDS);
    localparam logic [ptr_w-1:0] last_word = ptr_w'(`CONTENT_WORDS - 1);

    car_status_t      captured;
    logic [ptr_w-1:0] pointer;
    logic [7:0]       words [`CONTENT_WORDS];

    // snapshot of the car, held steady for the whole report
    always_ff @(posedge clock) begin
        if (clear) begin
            captured <= car_status;
        end
    end

    // parked on the last word so the first count lands on word 0
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pointer <= last_word;
        end else if (clear) begin
            pointer <= last_word;
        end else if (count_content) begin
            pointer <= pointer + 1'b1;
        end
    end

    // **************************************************
    // content words
    // **************************************************

    always_comb begin
        words[0] = {4'b0000, captured.floor};
        words[1] = {5'b00000, captured.door_open, captured.direction};
        words[2] = captured.load;
        words[3] = words[0] ^ words[1] ^ words[2];
    end

    assign content_byte = words[pointer];
    assign content_last = (pointer == last_word);

endmodule

/* hw/elevator_report.sv */
`timescale 1ns/1ns

module elevator_report (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          floor_changed,
    input  elev_report_pkg::car_status_t  car_status,
    input  elev_report_pkg::queue_write_t queue_write,
    output logic                          txd,
    output logic                          busy
);

    // control strobes and levels
    logic       is_content;
    logic       count_content;
    logic       count_queue;
    logic       send;
    logic       clear;

    // reader and transmitter results
    logic [7:0] content_byte;
    logic       content_last;
    logic [7:0] queue_byte;
    logic       queue_origin;
    logic       queue_last;
    logic       sent;

    report_control control_i (
        .clock         (clock),
        .reset         (reset),
        .floor_changed (floor_changed),
        .sent          (sent),
        .content_last  (content_last),
        .queue_last    (queue_last),
        .queue_origin  (queue_origin),
        .is_content    (is_content),
        .count_content (count_content),
        .count_queue   (count_queue),
        .send          (send),
        .clear         (clear),
        .busy          (busy)
    );

    content_reader content_i (
        .clock         (clock),
        .reset         (reset),
        .clear         (clear),
        .count_content (count_content),
        .car_status    (car_status),
        .content_byte  (content_byte),
        .content_last  (content_last)
    );

    queue_reader queue_i (
        .clock        (clock),
        .reset        (reset),
        .clear        (clear),
        .count_queue  (count_queue),
        .queue_write  (queue_write),
        .queue_byte   (queue_byte),
        .queue_origin (queue_origin),
        .queue_last   (queue_last)
    );

    serial_tx tx_i (
        .clock        (clock),
        .reset        (reset),
        .send         (send),
        .is_content   (is_content),
        .content_byte (content_byte),
        .queue_byte   (queue_byte),
        .txd          (txd),
        .sent         (sent)
    );

endmodule

/* hw/queue_reader.sv */
`timescale 1ns/1ns
`include "elev_report_defs.svh"

module queue_reader (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          clear,
    input  logic                          count_queue,
    input  elev_report_pkg::queue_write_t queue_write,
    output logic [7:0]                    queue_byte,
    output logic                          queue_origin,
    output logic                          queue_last
);

    import elev_report_pkg::*;

    localparam int ptr_w = $clog2(`QUEUE_DEPTH);
    localparam logic [ptr_w-1:0] last_entry = ptr_w'(`QUEUE_DEPTH - 1);

    queue_entry_u     entries [`QUEUE_DEPTH];
    queue_entry_u     current;
    logic [ptr_w-1:0] pointer;

    // **************************************************
    // queue storage
    // **************************************************

    // rows are filled from outside, only between reports
    always_ff @(posedge clock) begin
        if (queue_write.strobe) begin
            entries[queue_write.index] <= queue_write.entry;
        end
    end

    // **************************************************
    // read pointer
    // **************************************************

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pointer <= '0;
        end else if (clear) begin
            pointer <= '0;
        end else if (count_queue) begin
            pointer <= pointer + 1'b1;
        end
    end

    assign current = entries[pointer];

    // the tag sits in the same place in both views
    assign queue_origin = current.origin.tag;
    assign queue_byte   = current;
    assign queue_last   = (pointer == last_entry);

endmodule

/* hw/report_control.sv */
`timescale 1ns/1ns

module report_control (
    input  logic clock,
    input  logic reset,
    input  logic floor_changed,
    input  logic sent,
    input  logic content_last,
    input  logic queue_last,
    input  logic queue_origin,
    output logic is_content,
    output logic count_content,
    output logic count_queue,
    output logic send,
    output logic clear,
    output logic busy
);

    typedef enum logic [2:0] {
        st_idle          = 3'd0,
        st_prepare       = 3'd1,
        st_content_count = 3'd2,
        st_content_send  = 3'd3,
        st_queue_check   = 3'd4,
        st_queue_send    = 3'd5,
        st_queue_count   = 3'd6,
        st_done          = 3'd7
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // **************************************************
    // next state
    // **************************************************

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (floor_changed) begin
                    next_state = st_prepare;
                end
            end
            st_prepare: next_state = st_content_count;
            st_content_count: next_state = st_content_send;
            st_content_send: begin
                if (sent) begin
                    next_state = content_last ? st_queue_check : st_content_count;
                end
            end
            st_queue_check: begin
                // destination entries are stepped over without a transmission
                if (queue_origin) begin
                    next_state = st_queue_send;
                end else begin
                    next_state = queue_last ? st_done : st_queue_count;
                end
            end
            st_queue_send: begin
                if (sent) begin
                    next_state = queue_last ? st_done : st_queue_count;
                end
            end
            st_queue_count: next_state = st_queue_check;
            st_done: next_state = st_idle;
            default: next_state = st_idle;
        endcase
    end

    // outputs come from the registered state only
    always_comb begin
        clear         = (state == st_idle) || (state == st_prepare);
        busy          = (state != st_idle);
        count_content = (state == st_content_count);
        count_queue   = (state == st_queue_count);
        send          = (state == st_content_send) || (state == st_queue_send);
        is_content    = (state == st_content_send) || (state == st_content_count);
    end

endmodule

/* hw/serial_tx/serial_tx.sv */
`timescale 1ns/1ns
`include "elev_report_defs.svh"

module serial_tx (
    input  logic       clock,
    input  logic       reset,
    input  logic       send,
    input  logic       is_content,
    input  logic [7:0] content_byte,
    input  logic [7:0] queue_byte,
    output logic       txd,
    output logic       sent
);

    localparam int timer_w = $clog2(`CLKS_PER_BIT);
    localparam logic [timer_w-1:0] last_tick = timer_w'(`CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {
        tx_idle  = 2'd0,
        tx_start = 2'd1,
        tx_data  = 2'd2,
        tx_stop  = 2'd3
    } tx_state_t;

    tx_state_t          state;
    logic [timer_w-1:0] bit_timer;
    logic [2:0]         bit_index;
    logic [7:0]         shifter;
    logic [7:0]         selected;
    logic               bit_end;

    // the control unit picks which reader is being reported
    assign selected = is_content ? content_byte : queue_byte;
    assign bit_end  = (bit_timer == last_tick);

    // **************************************************
    // frame sequencing
    // **************************************************

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= tx_idle;
            bit_timer <= '0;
            bit_index <= '0;
        end else begin
            bit_timer <= (state == tx_idle || bit_end) ? '0 : bit_timer + 1'b1;
            case (state)
                tx_idle: begin
                    bit_index <= '0;
                    if (send) begin
                        state <= tx_start;
                    end
                end
                tx_start: begin
                    if (bit_end) begin
                        state <= tx_data;
                    end
                end
                tx_data: begin
                    if (bit_end) begin
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7) begin
                            state <= tx_stop;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= tx_idle;
                    end
                end
            endcase
        end
    end

    // byte is sampled on leaving idle, then shifted out lsb first
    always_ff @(posedge clock) begin
        if (state == tx_idle && send) begin
            shifter <= selected;
        end else if (state == tx_data && bit_end) begin
            shifter <= {1'b0, shifter[7:1]};
        end
    end

    assign txd  = (state == tx_start) ? 1'b0 : (state == tx_data) ? shifter[0] : 1'b1;
    assign sent = (state == tx_stop) && bit_end;

endmodule

/* src.f */
+incdir+common
common/elev_report_pkg.sv
hw/report_control.sv
hw/content_reader.sv
hw/queue_reader.sv
hw/serial_tx/serial_tx.sv
hw/elevator_report.sv
test/tb_clock_gen.sv
test/elevator_report_chk.sv
test/elevator_report_tb.sv

/* test/elevator_report_chk.sv */
`timescale 1ns/1ns

module elevator_report_chk (
    input logic       clock,
    input logic       reset,
    input logic [2:0] state,
    input logic       send,
    input logic       count_content,
    input logic       count_queue,
    input logic       clear,
    input logic       busy
);

    localparam logic [2:0] idle_code = 3'd0;

    int failures = 0;

    // a transmission and a pointer step never share a cycle
    send_apart_from_count: assert property (
        @(posedge clock) disable iff (reset)
        !(send && (count_content || count_queue))
    ) else begin
        failures++;
        $error("send is high together with a count pulse");
    end

    content_count_single: assert property (
        @(posedge clock) disable iff (reset)
        count_content |=> !count_content
    ) else begin
        failures++;
        $error("count_content lasted longer than one cycle");
    end

    queue_count_single: assert property (
        @(posedge clock) disable iff (reset)
        count_queue |=> !count_queue
    ) else begin
        failures++;
        $error("count_queue lasted longer than one cycle");
    end

    // the idle state always holds the readers cleared
    idle_cleared: assert property (
        @(posedge clock) disable iff (reset)
        (state == idle_code) |-> (busy || clear)
    ) else begin
        failures++;
        $error("busy and clear are both low in the idle state");
    end

endmodule

bind report_control elevator_report_chk chk_i (
    .clock         (clock),
    .reset         (reset),
    .state         (state),
    .send          (send),
    .count_content (count_content),
    .count_queue   (count_queue),
    .clear         (clear),
    .busy          (busy)
);

/* test/elevator_report_tb.sv */
`timescale 1ns/1ns
`include "elev_report_defs.svh"

module elevator_report_tb;

    import elev_report_pkg::*;

    localparam int bit_cycles    = `CLKS_PER_BIT;
    localparam int start_timeout = 24 * bit_cycles;
    localparam int idle_timeout  = 4 * bit_cycles;
    localparam int report_count  = 10;

    logic         clock;
    logic         reset;
    logic         floor_changed;
    car_status_t  car_status;
    queue_write_t queue_write;
    logic         txd;
    logic         busy;

    logic [31:0]  lfsr = 32'h233d;
    int           checks = 0;
    int           value_errors = 0;
    int           timeouts = 0;
    int           assert_failures;
    int           waited;

    tb_clock_gen clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    elevator_report dut_i (
        .clock         (clock),
        .reset         (reset),
        .floor_changed (floor_changed),
        .car_status    (car_status),
        .queue_write   (queue_write),
        .txd           (txd),
        .busy          (busy)
    );

    // **************************************************
    // helpers
    // **************************************************

    // x^32 + x^22 + x^2 + x + 1, one step per bit handed out
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(negedge clock);
    endtask

    task automatic write_entry(input int index, input queue_entry_u entry);
        queue_write.strobe = 1'b1;
        queue_write.index = 3'(index);
        queue_write.entry = entry;
        @(negedge clock);
        queue_write.strobe = 1'b0;
    endtask

    task automatic pulse_floor_changed();
        floor_changed = 1'b1;
        @(negedge clock);
        floor_changed = 1'b0;
    endtask

    // returns on a falling edge in the middle of the stop bit
    task automatic receive_byte(output logic [7:0] data, output bit ok);
        int cycles;
        ok = 1'b0;
        data = '0;
        cycles = 0;
        @(negedge clock);
        while (txd !== 1'b0 && cycles < start_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (txd !== 1'b0) begin
            timeouts++;
            $display("No start bit appeared on txd within %0d cycles", start_timeout);
        end else begin
            wait_cycles(bit_cycles / 2);
            check_value("txd start bit", txd, 1'b0);
            for (int i = 0; i < 8; i++) begin
                wait_cycles(bit_cycles);
                data[i] = txd;
            end
            wait_cycles(bit_cycles);
            check_value("txd stop bit", txd, 1'b1);
            ok = 1'b1;
        end
    endtask

    // after a report the line must stay quiet, extra pulses start nothing
    task automatic wait_for_idle(input int report_num);
        int cycles;
        cycles = 0;
        while (busy !== 1'b0 && cycles < idle_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (busy !== 1'b0) begin
            timeouts++;
            $display("busy stayed high after the last byte of report %0d", report_num);
        end else begin
            repeat (4 * bit_cycles) begin
                @(negedge clock);
                check_value("txd", txd, 1'b1);
                check_value("busy", busy, 1'b0);
            end
        end
    endtask

    // **************************************************
    // one report
    // **************************************************

    // queue_mode 0 mixes entries, 1 has no origin calls, 2 only origin calls
    task automatic run_report(input int report_num, input int queue_mode);
        car_status_t  status;
        queue_entry_u entry;
        logic [7:0]   queue_bytes [`QUEUE_DEPTH];
        logic [7:0]   expected [$];
        logic [7:0]   received;
        logic [1:0]   dir_bits;
        logic         is_origin;
        bit           ok;

        status.floor = 4'(random_bits(4));
        dir_bits = 2'(random_bits(2));
        if (dir_bits == 2'd3) begin
            dir_bits = 2'd0;
        end
        status.direction = direction_t'(dir_bits);
        status.door_open = 1'(random_bits(1));
        status.load = 8'(random_bits(8));
        car_status = status;

        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            case (queue_mode)
                0: is_origin = 1'(random_bits(1));
                1: is_origin = 1'b0;
                default: is_origin = 1'b1;
            endcase
            if (is_origin) begin
                entry.origin.tag = 1'b1;
                entry.origin.floor = 4'(random_bits(4));
                entry.origin.call_up = 1'(random_bits(1));
                entry.origin.spare = 2'(random_bits(2));
            end else begin
                entry.destination.tag = 1'b0;
                entry.destination.floor = 4'(random_bits(4));
                entry.destination.slot = 3'(random_bits(3));
            end
            queue_bytes[i] = entry;
            write_entry(i, entry);
        end

        // floor, flags, load, checksum, then origin calls in index order
        expected.push_back({4'h0, status.floor});
        expected.push_back({5'b00000, status.door_open, dir_bits});
        expected.push_back(status.load);
        expected.push_back(expected[0] ^ expected[1] ^ expected[2]);
        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            if (queue_bytes[i][7]) begin
                expected.push_back(queue_bytes[i]);
            end
        end

        pulse_floor_changed();
        ok = 1'b1;
        for (int n = 0; n < expected.size(); n++) begin
            receive_byte(received, ok);
            if (!ok) begin
                break;
            end
            check_value($sformatf("txd byte %0d of report %0d", n, report_num),
                        received, expected[n]);
            check_value("busy", busy, 1'b1);
            if (random_bits(1) == 32'd1) begin
                pulse_floor_changed();
            end
        end
        if (ok) begin
            wait_for_idle(report_num);
        end
    endtask

    // **************************************************
    // main sequence
    // **************************************************

    initial begin
        floor_changed = 1'b0;
        car_status = '0;
        queue_write = '0;
        waited = 0;
        while (reset !== 1'b0 && waited < 100) begin
            @(negedge clock);
            waited++;
        end
        if (reset !== 1'b0) begin
            timeouts++;
            $display("reset was never released");
        end else begin
            repeat (10 * bit_cycles) begin
                @(negedge clock);
                check_value("txd", txd, 1'b1);
                check_value("busy", busy, 1'b0);
            end
            run_report(0, 1);
            run_report(1, 2);
            for (int n = 2; n < report_count && timeouts == 0; n++) begin
                run_report(n, 0);
            end
        end

        assert_failures = dut_i.control_i.chk_i.failures;
        $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
                 checks, value_errors, timeouts, assert_failures);
        if (value_errors == 0 && timeouts == 0 && assert_failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    // reset covers four rising edges and is released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule
